// File: design/screenPkg.sv
`default_nettype none

package screenPkg;

	// Framebuffer geometry
	localparam int unsigned ScreenWidth = 160;
	localparam int unsigned ScreenHeight = 120;

	// Coordinate and colour widths
	localparam int unsigned XWidth = 8;
	localparam int unsigned YWidth = 7;
	localparam int unsigned ColorWidth = 3;

	// 4 Hz from a 50 MHz board clock
	localparam int unsigned TickPeriodDefault = 12_500_000;

	// Title images are vertical bars, scenes are horizontal bands
	localparam int unsigned TitleBarWidth = 20;
	localparam int unsigned SceneBandHeight = 15;

	// Picture chosen for one frame
	typedef enum logic [2:0] {
		Black = 3'd0,
		Title0 = 3'd1,
		Title1 = 3'd2,
		Title2 = 3'd3,
		Scene0 = 3'd4,
		Scene1 = 3'd5
	} imageT;

	// One pixel position, x is the column
	typedef struct packed {
		logic [XWidth-1:0] x;
		logic [YWidth-1:0] y;
	} coordT;

	// Scanned position, valid while the raster walk is active
	typedef struct packed {
		coordT coord;
		logic valid;
	} scanT;

	// Pixel write to the framebuffer
	typedef struct packed {
		coordT coord;
		logic [ColorWidth-1:0] color;
	} pixelT;

endpackage

`default_nettype wire

// File: design/screenController.sv
`timescale 1ns/1ps
`default_nettype none

module screenController (
	input wire logic clk,
	input wire logic rstN,
	input wire logic userCont,
	input wire logic tick,
	input wire logic scanDone,
	output screenPkg::imageT image,
	output logic frameStart
);

	// Idle only after reset, then load and draw for each image
	typedef enum logic [1:0] {
		Idle = 2'd0,
		Load = 2'd1,
		Draw = 2'd2
	} stateT;

	stateT state;
	stateT nextState;

	screenPkg::imageT nextImage;

	// Title images react to the continue key
	logic isTitle;
	// Draw state is done with the current image
	logic advance;

	always_comb begin
		isTitle = (image == screenPkg::Title0) ||
			(image == screenPkg::Title1) ||
			(image == screenPkg::Title2);
	end

	// Black clear runs to the end of the scan, the rest wait on the timer
	always_comb begin
		if (image == screenPkg::Black) begin
			advance = scanDone;
		end else begin
			advance = tick || (isTitle && userCont);
		end
	end

	// Next picture
	always_comb begin
		case (image)
			screenPkg::Black: begin
				nextImage = screenPkg::Title0;
			end
			// Continue wins over the rotation
			screenPkg::Title0: begin
				nextImage = userCont ? screenPkg::Scene0 : screenPkg::Title1;
			end
			screenPkg::Title1: begin
				nextImage = userCont ? screenPkg::Scene0 : screenPkg::Title2;
			end
			screenPkg::Title2: begin
				nextImage = userCont ? screenPkg::Scene0 : screenPkg::Title0;
			end
			// Scenes just alternate
			screenPkg::Scene0: begin
				nextImage = screenPkg::Scene1;
			end
			screenPkg::Scene1: begin
				nextImage = screenPkg::Scene0;
			end
			default: begin
				nextImage = screenPkg::Black;
			end
		endcase
	end

	// State sequencing
	always_comb begin
		case (state)
			Idle: begin
				nextState = Load;
			end
			// Single cycle, kicks off scanner and timer
			Load: begin
				nextState = Draw;
			end
			Draw: begin
				nextState = advance ? Load : Draw;
			end
			default: begin
				nextState = Idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	// Power-on picture is the black clear
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			image <= screenPkg::Black;
		end else if (state == Draw && advance) begin
			image <= nextImage;
		end
	end

	// Restarts both the raster scan and the delay counter
	always_comb begin
		frameStart = (state == Load);
	end

	// Picture stays fixed while the scanner walks the frame
	imageHeldInDraw: assert property (
		@(posedge clk) disable iff (!rstN)
		(state == Draw) && ($past(state) == Draw) |-> $stable(image)
	);

endmodule

`default_nettype wire

// File: design/frameTimer.sv
`timescale 1ns/1ps
`default_nettype none

module frameTimer #(
	parameter int unsigned tickPeriod = screenPkg::TickPeriodDefault
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic frameStart,
	output logic tick
);

	// Wide enough for tickPeriod - 1
	typedef logic [$clog2(tickPeriod)-1:0] countT;

	countT count;
	// Counting since the last frameStart
	logic running;

	// Expiry, tickPeriod cycles after the reload
	always_comb begin
		tick = running && (count == '0);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
			running <= 1'b0;
		end else if (frameStart) begin
			// Reload wins, even mid count
			count <= countT'(tickPeriod - 1);
			running <= 1'b1;
		end else if (tick) begin
			// One shot, idle until reloaded
			running <= 1'b0;
		end else if (running) begin
			count <= count - 1'b1;
		end
	end

	// Single pulse per frame
	tickOneCycle: assert property (
		@(posedge clk) disable iff (!rstN)
		tick && !frameStart |=> !tick
	);

endmodule

`default_nettype wire

// File: design/pixelScanner.sv
`timescale 1ns/1ps
`default_nettype none

module pixelScanner (
	input wire logic clk,
	input wire logic rstN,
	input wire logic frameStart,
	output screenPkg::scanT scan,
	output logic scanDone
);

	screenPkg::coordT pos;
	// Raster walk in progress
	logic active;

	logic lastColumn;
	logic lastRow;

	always_comb begin
		lastColumn = (int'(pos.x) == screenPkg::ScreenWidth - 1);
		lastRow = (int'(pos.y) == screenPkg::ScreenHeight - 1);
	end

	// x runs fastest, y steps at the end of each row
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pos <= '0;
			active <= 1'b0;
			scanDone <= 1'b0;
		end else if (frameStart) begin
			// Restart from (0,0), also mid frame
			pos <= '0;
			active <= 1'b1;
			scanDone <= 1'b0;
		end else if (active) begin
			if (lastColumn) begin
				pos.x <= '0;
				if (lastRow) begin
					// Last pixel out, stop and flag it
					active <= 1'b0;
					scanDone <= 1'b1;
				end else begin
					pos.y <= pos.y + 1'b1;
				end
			end else begin
				pos.x <= pos.x + 1'b1;
			end
		end else begin
			scanDone <= 1'b0;
		end
	end

	always_comb begin
		scan.coord = pos;
		scan.valid = active;
	end

	// Never walks off the framebuffer
	scanInsideScreen: assert property (
		@(posedge clk) disable iff (!rstN)
		scan.valid |-> (int'(scan.coord.x) < screenPkg::ScreenWidth) &&
			(int'(scan.coord.y) < screenPkg::ScreenHeight)
	);

endmodule

`default_nettype wire

// File: design/pixelPalette.sv
`timescale 1ns/1ps
`default_nettype none

module pixelPalette (
	input wire logic clk,
	input wire logic rstN,
	input wire screenPkg::imageT image,
	input wire screenPkg::scanT scan,
	output logic plot,
	output screenPkg::pixelT pixel
);

	// Which bar or band the pixel falls in
	int unsigned barIndex;
	int unsigned bandIndex;
	// Colour before wrapping to 3 bits
	int unsigned colorSum;

	logic [screenPkg::ColorWidth-1:0] color;

	always_comb begin
		barIndex = int'(scan.coord.x) / screenPkg::TitleBarWidth;
		bandIndex = int'(scan.coord.y) / screenPkg::SceneBandHeight;
		case (image)
			// Titles shift the bar colours by their index
			screenPkg::Title0: begin
				colorSum = barIndex;
			end
			screenPkg::Title1: begin
				colorSum = barIndex + 1;
			end
			screenPkg::Title2: begin
				colorSum = barIndex + 2;
			end
			// Scenes skip colour 0 on the first band
			screenPkg::Scene0: begin
				colorSum = bandIndex + 1;
			end
			screenPkg::Scene1: begin
				colorSum = bandIndex + 4;
			end
			default: begin
				colorSum = 0;
			end
		endcase
		// Modulo 8
		color = colorSum[screenPkg::ColorWidth-1:0];
	end

	// Write strobe lines up with the registered pixel
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			plot <= 1'b0;
		end else begin
			plot <= scan.valid;
		end
	end

	always_ff @(posedge clk) begin
		pixel.coord <= scan.coord;
		pixel.color <= color;
	end

endmodule

`default_nettype wire

// File: design/screenTop.sv
`timescale 1ns/1ps
`default_nettype none

module screenTop #(
	parameter int unsigned tickPeriod = screenPkg::TickPeriodDefault
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic userCont,
	output logic plot,
	output screenPkg::pixelT pixel
);

	// Controller to datapath
	screenPkg::imageT image;
	logic frameStart;

	// Datapath back to controller
	logic tick;
	logic scanDone;

	// Scanner to palette
	screenPkg::scanT scan;

	// Sequences clear, titles and scenes
	screenController i_screenController (
		.clk(clk),
		.rstN(rstN),
		.userCont(userCont),
		.tick(tick),
		.scanDone(scanDone),
		.image(image),
		.frameStart(frameStart)
	);

	// Delay between images, restarted each frame
	frameTimer #(
		.tickPeriod(tickPeriod)
	) i_frameTimer (
		.clk(clk),
		.rstN(rstN),
		.frameStart(frameStart),
		.tick(tick)
	);

	// 160x120 raster walk
	pixelScanner i_pixelScanner (
		.clk(clk),
		.rstN(rstN),
		.frameStart(frameStart),
		.scan(scan),
		.scanDone(scanDone)
	);

	// Colour lookup and framebuffer write
	pixelPalette i_pixelPalette (
		.clk(clk),
		.rstN(rstN),
		.image(image),
		.scan(scan),
		.plot(plot),
		.pixel(pixel)
	);

endmodule

`default_nettype wire

// File: verification/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk
);

	// 100 ns period, 10 MHz
	localparam int HalfPeriod = 50;

	initial begin
		clk = 1'b0;
		forever begin
			#HalfPeriod;
			clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: verification/screenTb.sv
`timescale 1ns/1ps
`default_nettype none

module screenTb;

	// Short tick so a run stays small, still longer than one frame
	localparam int unsigned TickPeriod = 20_000;
	localparam int DriveDelay = 10;
	localparam int Width = int'(screenPkg::ScreenWidth);
	localparam int Height = int'(screenPkg::ScreenHeight);
	localparam int FramePixels = Width * Height;
	// Gap between frames is about TickPeriod minus a frame
	localparam int WaitLimit = 30_000;
	localparam int ColorRange = 1 << screenPkg::ColorWidth;

	logic clk;
	logic rstN;
	logic userCont;
	logic plot;
	screenPkg::pixelT pixel;

	int mismatchCount;
	int timeoutCount;

	tbClock i_clock (
		.clk(clk)
	);

	screenTop #(
		.tickPeriod(TickPeriod)
	) i_dut (
		.clk(clk),
		.rstN(rstN),
		.userCont(userCont),
		.plot(plot),
		.pixel(pixel)
	);

	// Reference colour straight from the palette rule
	function automatic int expectedColor(input screenPkg::imageT img, input int x, input int y);
		int bar;
		int band;
		bar = x / int'(screenPkg::TitleBarWidth);
		band = y / int'(screenPkg::SceneBandHeight);
		case (img)
			screenPkg::Title0: return bar % ColorRange;
			screenPkg::Title1: return (bar + 1) % ColorRange;
			screenPkg::Title2: return (bar + 2) % ColorRange;
			// Scene J adds 1 + 3J
			screenPkg::Scene0: return (band + 1) % ColorRange;
			screenPkg::Scene1: return (band + 1 + 3) % ColorRange;
			default: return 0;
		endcase
	endfunction

	task automatic compareValue(input string testName, input string what, input int expected,
		input int actual);
		if (expected !== actual) begin
			$display("** Error %s: %s expected %0d, actual %0d", testName, what, expected,
				actual);
			mismatchCount++;
		end
	endtask

	// Samples on the falling edge, half a period after the DUT updates
	task automatic waitForPlot(input string testName, input logic level, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < WaitLimit && !ok; n++) begin
			@(negedge clk);
			if (plot === level) begin
				ok = 1'b1;
			end
		end
		if (!ok) begin
			$display("Timeout in %s: plot did not go to %0d within %0d cycles", testName,
				level, WaitLimit);
			timeoutCount++;
		end
	endtask

	// One full frame, raster order with x fastest, then plot low again
	task automatic captureFrame(input string testName, input screenPkg::imageT img);
		bit ok;
		int x;
		int y;
		waitForPlot(testName, 1'b0, ok);
		if (ok) begin
			waitForPlot(testName, 1'b1, ok);
		end
		if (ok) begin
			for (int i = 0; i < FramePixels; i++) begin
				// First pixel already sits on the edge that saw the rise
				if (i > 0) begin
					@(negedge clk);
				end
				x = i % Width;
				y = i / Width;
				compareValue(testName, "plot", 1, int'(plot));
				compareValue(testName, "x", x, int'(pixel.coord.x));
				compareValue(testName, "y", y, int'(pixel.coord.y));
				compareValue(testName, "color", expectedColor(img, x, y),
					int'(pixel.color));
			end
			@(negedge clk);
			compareValue(testName, "plot after last pixel", 0, int'(plot));
		end
	endtask

	// Reset for 3 cycles, plot must stay low throughout
	task automatic holdReset(input string testName);
		@(posedge clk);
		#DriveDelay;
		rstN = 1'b0;
		repeat (3) begin
			@(negedge clk);
			compareValue(testName, "plot in reset", 0, int'(plot));
		end
		@(posedge clk);
		#DriveDelay;
		rstN = 1'b1;
	endtask

	// Continue key held for a few cycles in the middle of a frame
	task automatic pulseContinue(input string testName);
		bit ok;
		waitForPlot(testName, 1'b1, ok);
		repeat (3000) @(posedge clk);
		#DriveDelay;
		userCont = 1'b1;
		repeat (10) @(posedge clk);
		#DriveDelay;
		userCont = 1'b0;
	endtask

	task automatic resetAndClear();
		$display("Running resetAndClear");
		holdReset("resetAndClear");
		captureFrame("resetAndClear", screenPkg::Black);
	endtask

	task automatic titleContent();
		$display("Running titleContent");
		captureFrame("titleContent", screenPkg::Title0);
	endtask

	task automatic titleRotation();
		$display("Running titleRotation");
		captureFrame("titleRotation", screenPkg::Title1);
		captureFrame("titleRotation", screenPkg::Title2);
		captureFrame("titleRotation", screenPkg::Title0);
	endtask

	// Key pressed in the gap after a title frame, still its draw state
	task automatic continueToScene();
		$display("Running continueToScene");
		@(posedge clk);
		#DriveDelay;
		userCont = 1'b1;
		@(posedge clk);
		#DriveDelay;
		userCont = 1'b0;
		captureFrame("continueToScene", screenPkg::Scene0);
		captureFrame("continueToScene", screenPkg::Scene1);
		captureFrame("continueToScene", screenPkg::Scene0);
	endtask

	task automatic sceneIgnoresContinue();
		$display("Running sceneIgnoresContinue");
		fork
			captureFrame("sceneIgnoresContinue", screenPkg::Scene1);
			pulseContinue("sceneIgnoresContinue");
		join
		captureFrame("sceneIgnoresContinue", screenPkg::Scene0);
		captureFrame("sceneIgnoresContinue", screenPkg::Scene1);
	endtask

	// Controller falls back to the black clear
	task automatic resetMidFrame();
		bit ok;
		$display("Running resetMidFrame");
		waitForPlot("resetMidFrame", 1'b1, ok);
		repeat (5000) @(posedge clk);
		holdReset("resetMidFrame");
		captureFrame("resetMidFrame", screenPkg::Black);
	endtask

	initial begin
		rstN = 1'b0;
		userCont = 1'b0;
		mismatchCount = 0;
		timeoutCount = 0;

		resetAndClear();
		titleContent();
		titleRotation();
		continueToScene();
		sceneIgnoresContinue();
		resetMidFrame();

		$display("Summary: %0d value mismatches, %0d timeouts", mismatchCount, timeoutCount);
		if (mismatchCount == 0 && timeoutCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: screenDisplay.f
design/screenPkg.sv
design/screenController.sv
design/frameTimer.sv
design/pixelScanner.sv
design/pixelPalette.sv
design/screenTop.sv
verification/tbClock.sv
verification/screenTb.sv

// File: Makefile
# Verilator build of the frame sequencer testbench

VERILATOR ?= verilator
TOP ?= screenTb
FILELIST ?= screenDisplay.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed!

SOURCES := $(wildcard design/*.sv) $(wildcard verification/*.sv)
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the simulator exit code
run: compile
	$(BINARY) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
